//--- ctrl_pkg.sv
// matrix-engine controller definitions
package ctrl_pkg;

    // operating phase of the cluster
    typedef enum logic [1:0] {
        PH_IDLE  = 2'd0,
        PH_Q_GEN = 2'd1,
        PH_PROJ  = 2'd2
    } phase_e;

    ////////////////////
    // cluster constants
    ////////////////////

    localparam int LANES            = 8;    // slices per bus line
    localparam int PROJ_WEIGHT_BASE = 512;  // q_gen weights start at 0
    localparam int BIAS_HEAD        = 1;    // head buffer target
    localparam int BIAS_RESID       = 2;    // residual buffer target

    ////////////////////
    // width types
    ////////////////////

    // column limit or write count, 1 to 64
    typedef logic [6:0] col_cnt_t;

    typedef logic [8:0] embd_t;         // embedding size up to 256
    typedef logic [8:0] col_idx_t;      // global column index

    // bus address split into line and slice
    typedef logic [5:0] line_t;
    typedef logic [2:0] slice_t;
    typedef logic [1:0] bias_t;

    typedef logic [9:0] wmem_addr_t;    // wraps at the top

    typedef logic [15:0] res_data_t;

endpackage

//--- wr_if.sv
// core write beat interface
`timescale 1ns/1ps

interface wr_if;

    logic                valid;
    logic                ready;
    ctrl_pkg::bias_t     bias;     // bus target
    ctrl_pkg::line_t     line;
    ctrl_pkg::slice_t    slice;
    ctrl_pkg::res_data_t data;

    // beat moves on valid and ready, fields held until then
    modport source (
        output valid,
        output bias,
        output line,
        output slice,
        output data,
        input  ready
    );

    modport sink (
        input  valid,
        input  bias,
        input  line,
        input  slice,
        input  data,
        output ready
    );

endinterface

//--- phase_dispatch.sv
// phase dispatcher
`timescale 1ns/1ps

module phase_dispatch #(
    parameter int NUM_CORES = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ctrl_pkg::phase_e     phase_in,
    input  logic                 phase_update,
    input  logic                 start,
    input  ctrl_pkg::col_cnt_t   cfg_cols_per_core,
    input  ctrl_pkg::embd_t      cfg_embd_size,
    input  logic [NUM_CORES-1:0] core_finish,
    output ctrl_pkg::phase_e     phase,
    output logic                 core_start,
    output ctrl_pkg::col_cnt_t   col_limit,
    output logic                 recompute_needed,
    output logic                 phase_done
);

    // embedding split evenly over the cores
    localparam int CORE_SHIFT = $clog2(NUM_CORES);

    logic [NUM_CORES-1:0] finish_seen;  // sticky, one per core
    logic [NUM_CORES-1:0] finish_all;

    ////////////////////
    // phase and start
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= ctrl_pkg::PH_IDLE;
        end else if (phase_update) begin
            phase <= phase_in;
        end
    end

    // start reaches the cores one cycle late
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            core_start <= 1'b0;
        end else begin
            core_start <= start;
        end
    end

    // per-core column count, cfg held for the whole phase
    always_comb begin
        case (phase)
            ctrl_pkg::PH_Q_GEN: col_limit = cfg_cols_per_core;
            ctrl_pkg::PH_PROJ:  col_limit = ctrl_pkg::col_cnt_t'(cfg_embd_size >> CORE_SHIFT);
            default:            col_limit = '0;
        endcase
    end

    assign recompute_needed = (phase == ctrl_pkg::PH_Q_GEN);  // only q_gen

    ////////////////////
    // finish collection
    ////////////////////

    assign finish_all = finish_seen | core_finish;

    // done fires on the edge where the last missing bit arrives
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            finish_seen <= '0;
            phase_done  <= 1'b0;
        end else begin
            phase_done <= (&finish_all) && !(&finish_seen);
            if (core_start) begin
                finish_seen <= '0;
            end else begin
                finish_seen <= finish_all;
            end
        end
    end

endmodule

//--- core_ctrl.sv
// core read pointer and write address generator
`timescale 1ns/1ps

module core_ctrl #(
    parameter int CORE_INDEX = 0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ctrl_pkg::phase_e     phase,
    input  logic                 core_start,
    input  ctrl_pkg::col_cnt_t   col_limit,
    input  logic                 act_valid,
    input  logic                 res_valid,
    input  ctrl_pkg::res_data_t  res_data,
    output logic                 res_ready,
    output logic                 wmem_ren,
    output ctrl_pkg::wmem_addr_t wmem_raddr,
    output logic                 finish,
    wr_if.source                 wr
);

    logic                 active;     // between core_start and last beat
    logic                 all_taken;  // last result already accepted
    ctrl_pkg::col_cnt_t   wr_cnt;     // results accepted so far
    ctrl_pkg::col_idx_t   col_idx;    // column of the next result
    ctrl_pkg::wmem_addr_t rd_base;
    ctrl_pkg::bias_t      wr_bias;
    logic                 res_fire;
    logic                 beat_xfer;
    logic                 last_xfer;

    // phase decode
    assign rd_base = (phase == ctrl_pkg::PH_PROJ) ?
                     ctrl_pkg::wmem_addr_t'(ctrl_pkg::PROJ_WEIGHT_BASE) : '0;
    assign wr_bias = (phase == ctrl_pkg::PH_PROJ) ?
                     ctrl_pkg::bias_t'(ctrl_pkg::BIAS_RESID) :
                     ctrl_pkg::bias_t'(ctrl_pkg::BIAS_HEAD);

    assign beat_xfer = wr.valid & wr.ready;
    assign last_xfer = beat_xfer & all_taken;  // stage holds the final beat

    // stage free or draining this cycle
    assign res_ready = active & ~all_taken & (~wr.valid | wr.ready);
    assign res_fire  = res_valid & res_ready;

    ////////////////////
    // read pointer
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wmem_ren   <= 1'b0;
            wmem_raddr <= '0;
        end else begin
            wmem_ren <= active & ~last_xfer & act_valid;  // one read per act beat
            if (core_start) begin
                wmem_raddr <= rd_base;
            end else if (wmem_ren) begin
                wmem_raddr <= wmem_raddr + 1'b1;
            end
        end
    end

    ////////////////////
    // write counters
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            all_taken <= 1'b0;
            wr_cnt    <= '0;
            col_idx   <= '0;
            finish    <= 1'b0;
        end else begin
            finish <= last_xfer;
            if (core_start) begin
                active    <= 1'b1;
                all_taken <= 1'b0;
                wr_cnt    <= '0;
                col_idx   <= ctrl_pkg::col_idx_t'(CORE_INDEX * col_limit);  // slice start
            end else begin
                if (last_xfer) begin
                    active <= 1'b0;
                end
                if (res_fire) begin
                    wr_cnt  <= wr_cnt + 1'b1;
                    col_idx <= col_idx + 1'b1;
                    if (wr_cnt == col_limit - 1'b1) begin
                        all_taken <= 1'b1;
                    end
                end
            end
        end
    end

    ////////////////////
    // output stage
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr.valid <= 1'b0;
        end else if (res_fire) begin
            wr.valid <= 1'b1;
        end else if (beat_xfer) begin
            wr.valid <= 1'b0;
        end
    end

    // line and slice from the column index
    always_ff @(posedge clk) begin
        if (res_fire) begin
            wr.bias  <= wr_bias;
            wr.line  <= ctrl_pkg::line_t'(col_idx / ctrl_pkg::LANES);
            wr.slice <= ctrl_pkg::slice_t'(col_idx % ctrl_pkg::LANES);
            wr.data  <= res_data;
        end
    end

endmodule

//--- gbus_write_arb.sv
// round-robin global bus write arbiter
`timescale 1ns/1ps

module gbus_write_arb #(
    parameter int NUM_CORES = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                gbus_ready,
    wr_if.sink                  wr [NUM_CORES],
    output logic                gbus_wen,
    output ctrl_pkg::bias_t     gbus_bias,
    output ctrl_pkg::line_t     gbus_line,
    output ctrl_pkg::slice_t    gbus_slice,
    output ctrl_pkg::res_data_t gbus_wdata
);

    localparam int IDX_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

    logic [NUM_CORES-1:0] req;
    logic [NUM_CORES-1:0] gnt;
    ctrl_pkg::bias_t      req_bias  [NUM_CORES];
    ctrl_pkg::line_t      req_line  [NUM_CORES];
    ctrl_pkg::slice_t     req_slice [NUM_CORES];
    ctrl_pkg::res_data_t  req_data  [NUM_CORES];
    logic [IDX_W-1:0]     last_idx;   // last granted core
    logic [IDX_W-1:0]     win_idx;
    logic                 win_found;
    logic                 can_load;   // output register free or leaving

    // flatten the interface array
    for (genvar g = 0; g < NUM_CORES; g++) begin : g_port
        assign req[g]       = wr[g].valid;
        assign req_bias[g]  = wr[g].bias;
        assign req_line[g]  = wr[g].line;
        assign req_slice[g] = wr[g].slice;
        assign req_data[g]  = wr[g].data;
        assign wr[g].ready  = gnt[g];
    end

    assign can_load = ~gbus_wen | gbus_ready;

    // search starts one past the previous winner
    always_comb begin
        int cand;
        win_found = 1'b0;
        win_idx   = last_idx;
        for (int k = 1; k <= NUM_CORES; k++) begin
            cand = (int'(last_idx) + k) % NUM_CORES;
            if (!win_found && req[cand]) begin
                win_found = 1'b1;
                win_idx   = IDX_W'(cand);
            end
        end
    end

    always_comb begin
        gnt = '0;
        if (win_found && can_load) begin
            gnt[win_idx] = 1'b1;
        end
    end

    ////////////////////
    // bus output register
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gbus_wen <= 1'b0;
            last_idx <= '0;
        end else if (can_load) begin
            gbus_wen <= win_found;
            if (win_found) begin
                last_idx <= win_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (can_load && win_found) begin
            gbus_bias  <= req_bias[win_idx];
            gbus_line  <= req_line[win_idx];
            gbus_slice <= req_slice[win_idx];
            gbus_wdata <= req_data[win_idx];
        end
    end

endmodule

//--- head_ctrl_top.sv
// matrix-engine cluster controller
`timescale 1ns/1ps

module head_ctrl_top #(
    parameter int NUM_CORES = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    // dispatcher
    input  ctrl_pkg::phase_e     phase_in,
    input  logic                 phase_update,
    input  logic                 start,
    input  ctrl_pkg::col_cnt_t   cfg_cols_per_core,
    input  ctrl_pkg::embd_t      cfg_embd_size,
    output ctrl_pkg::phase_e     phase,
    output logic                 recompute_needed,
    output logic                 phase_done,
    // per-core streams
    input  logic                 act_valid,
    input  logic [NUM_CORES-1:0] res_valid,
    input  ctrl_pkg::res_data_t  res_data [NUM_CORES],
    output logic [NUM_CORES-1:0] res_ready,
    output logic [NUM_CORES-1:0] wmem_ren,
    output ctrl_pkg::wmem_addr_t wmem_raddr [NUM_CORES],
    // global bus
    input  logic                 gbus_ready,
    output logic                 gbus_wen,
    output ctrl_pkg::bias_t      gbus_bias,
    output ctrl_pkg::line_t      gbus_line,
    output ctrl_pkg::slice_t     gbus_slice,
    output ctrl_pkg::res_data_t  gbus_wdata
);

    logic                 core_start;
    ctrl_pkg::col_cnt_t   col_limit;
    logic [NUM_CORES-1:0] core_finish;

    wr_if wr_bus [NUM_CORES] ();  // core to arbiter

    phase_dispatch #(
        .NUM_CORES (NUM_CORES)
    ) i_phase_dispatch (
        .clk               (clk),
        .rst_n             (rst_n),
        .phase_in          (phase_in),
        .phase_update      (phase_update),
        .start             (start),
        .cfg_cols_per_core (cfg_cols_per_core),
        .cfg_embd_size     (cfg_embd_size),
        .core_finish       (core_finish),
        .phase             (phase),
        .core_start        (core_start),
        .col_limit         (col_limit),
        .recompute_needed  (recompute_needed),
        .phase_done        (phase_done)
    );

    for (genvar g = 0; g < NUM_CORES; g++) begin : g_core
        core_ctrl #(
            .CORE_INDEX (g)
        ) i_core_ctrl (
            .clk        (clk),
            .rst_n      (rst_n),
            .phase      (phase),
            .core_start (core_start),
            .col_limit  (col_limit),
            .act_valid  (act_valid),
            .res_valid  (res_valid[g]),
            .res_data   (res_data[g]),
            .res_ready  (res_ready[g]),
            .wmem_ren   (wmem_ren[g]),
            .wmem_raddr (wmem_raddr[g]),
            .finish     (core_finish[g]),
            .wr         (wr_bus[g])
        );
    end

    gbus_write_arb #(
        .NUM_CORES (NUM_CORES)
    ) i_gbus_write_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .gbus_ready (gbus_ready),
        .wr         (wr_bus),
        .gbus_wen   (gbus_wen),
        .gbus_bias  (gbus_bias),
        .gbus_line  (gbus_line),
        .gbus_slice (gbus_slice),
        .gbus_wdata (gbus_wdata)
    );

endmodule

//--- head_ctrl_sva.sv
// cluster controller properties
`timescale 1ns/1ps

module head_ctrl_sva #(
    parameter int NUM_CORES = 4
) (
    input logic                 clk,
    input logic                 rst_n,
    input ctrl_pkg::phase_e     phase,
    input logic [NUM_CORES-1:0] wmem_ren,
    input logic                 phase_done,
    input logic                 gbus_ready,
    input logic                 gbus_wen,
    input ctrl_pkg::bias_t      gbus_bias,
    input ctrl_pkg::line_t      gbus_line,
    input ctrl_pkg::slice_t     gbus_slice,
    input ctrl_pkg::res_data_t  gbus_wdata
);

    // stalled beat keeps all its fields
    a_gbus_hold: assert property (@(posedge clk) disable iff (!rst_n)
        gbus_wen && !gbus_ready |=> gbus_wen &&
        $stable({gbus_bias, gbus_line, gbus_slice, gbus_wdata}))
        else $error("gbus fields changed under back-pressure");

    a_idle_no_read: assert property (@(posedge clk) disable iff (!rst_n)
        phase == ctrl_pkg::PH_IDLE |-> wmem_ren == '0)
        else $error("weight read while phase is idle");

    // single-cycle done
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        phase_done |=> !phase_done)
        else $error("phase_done held longer than one cycle");

endmodule

bind head_ctrl_top head_ctrl_sva #(.NUM_CORES(NUM_CORES)) i_head_ctrl_sva (.*);

//--- tb_head_ctrl_top.sv
// cluster controller testbench
`timescale 1ns/1ps

module tb_head_ctrl_top;

    localparam int NUM_CORES  = 4;
    localparam int CLK_PERIOD = 8;
    localparam int EXP_WRITES = 2 * NUM_CORES * (12 + 64 / NUM_CORES);  // two q_gen + two proj

    logic                 clk;
    logic                 rst_n;
    ctrl_pkg::phase_e     phase_in;
    logic                 phase_update;
    logic                 start;
    ctrl_pkg::col_cnt_t   cfg_cols_per_core;
    ctrl_pkg::embd_t      cfg_embd_size;
    ctrl_pkg::phase_e     phase;
    logic                 recompute_needed;
    logic                 phase_done;
    logic                 act_valid;
    logic [NUM_CORES-1:0] res_valid;
    ctrl_pkg::res_data_t  res_data [NUM_CORES];
    logic [NUM_CORES-1:0] res_ready;
    logic [NUM_CORES-1:0] wmem_ren;
    ctrl_pkg::wmem_addr_t wmem_raddr [NUM_CORES];
    logic                 gbus_ready;
    logic                 gbus_wen;
    ctrl_pkg::bias_t      gbus_bias;
    ctrl_pkg::line_t      gbus_line;
    ctrl_pkg::slice_t     gbus_slice;
    ctrl_pkg::res_data_t  gbus_wdata;

    // scoreboard state
    ctrl_pkg::phase_e cur_ph;
    int cur_cols, cur_embd, lim, total, acc, done_cnt, rd_base;
    int exp_seq [NUM_CORES];
    int rd_cnt  [NUM_CORES];
    int drv_seq [NUM_CORES];
    logic rand_ready;

    head_ctrl_top #(.NUM_CORES(NUM_CORES)) i_head_ctrl_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_error(input string what);
        $display("[ERROR] %0t: %s", $time, what);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string sig, input int exp_v, input int got_v);
        stop_on_error($sformatf("%s expected %0d got %0d", sig, exp_v, got_v));
    endtask

    // expected {bias, line, slice} of one result
    function automatic logic [10:0] expect_addr(input ctrl_pkg::phase_e ph, input int cols,
                                                input int embd, input int core, input int seq);
        int col_lim;
        int col;
        int b;
        col_lim = (ph == ctrl_pkg::PH_PROJ) ? embd / NUM_CORES : cols;
        col     = core * col_lim + seq;
        b       = (ph == ctrl_pkg::PH_PROJ) ? ctrl_pkg::BIAS_RESID : ctrl_pkg::BIAS_HEAD;
        return {ctrl_pkg::bias_t'(b), ctrl_pkg::line_t'(col / ctrl_pkg::LANES),
                ctrl_pkg::slice_t'(col % ctrl_pkg::LANES)};
    endfunction

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        int seq_n;
        void'($urandom(4248));
        act_valid  = 1'b0;
        res_valid  = '0;
        gbus_ready = 1'b0;
        for (int c = 0; c < NUM_CORES; c++) begin
            res_data[c] = '0;
        end
        wait (rst_n);
        forever begin
            @(posedge clk);
            act_valid  <= ($urandom % 4) != 0;
            gbus_ready <= rand_ready ? (($urandom % 3) != 0) : 1'b1;
            for (int c = 0; c < NUM_CORES; c++) begin
                seq_n = drv_seq[c];
                if (res_valid[c] && res_ready[c]) seq_n++;  // accepted at this edge
                drv_seq[c] = seq_n;
                if (res_valid[c] && !res_ready[c]) begin
                    res_valid[c] <= 1'b1;                 // hold until taken
                end else if (seq_n < lim && ($urandom % 2) == 1) begin
                    res_valid[c] <= 1'b1;
                    res_data[c]  <= {2'(c), 14'(seq_n)};  // core number on top
                end else begin
                    res_valid[c] <= 1'b0;
                end
            end
        end
    end

    ////////////////////
    // checker
    ////////////////////

    always @(negedge clk) begin
        int c;
        int s;
        logic [10:0] exp_a;
        if (rst_n) begin
            if (phase_done) begin
                assert (done_cnt == 0)
                    else stop_on_error("phase_done pulsed twice in one phase");
                assert (acc + int'(gbus_wen) == total)
                    else stop_on_error("phase_done came before all beats reached the bus");
                done_cnt++;
            end
            if (gbus_wen && gbus_ready) begin
                c     = gbus_wdata[15:14];
                s     = gbus_wdata[13:0];
                exp_a = expect_addr(cur_ph, cur_cols, cur_embd, c, s);
                assert (s == exp_seq[c])
                    else report_mismatch("gbus_wdata seq", exp_seq[c], s);
                assert (gbus_bias == exp_a[10:9])
                    else report_mismatch("gbus_bias", exp_a[10:9], gbus_bias);
                assert (gbus_line == exp_a[8:3])
                    else report_mismatch("gbus_line", exp_a[8:3], gbus_line);
                assert (gbus_slice == exp_a[2:0])
                    else report_mismatch("gbus_slice", exp_a[2:0], gbus_slice);
                exp_seq[c]++;
                acc++;
            end
            for (int k = 0; k < NUM_CORES; k++) begin
                // all results of this core already taken
                assert (!(res_ready[k] && drv_seq[k] >= lim))
                    else stop_on_error($sformatf("core %0d ready after its last result", k));
                if (wmem_ren[k]) begin
                    assert (exp_seq[k] < lim)
                        else stop_on_error($sformatf("core %0d read after its last beat", k));
                    assert (wmem_raddr[k] == ctrl_pkg::wmem_addr_t'(rd_base + rd_cnt[k]))
                        else report_mismatch($sformatf("wmem_raddr[%0d]", k),
                            ctrl_pkg::wmem_addr_t'(rd_base + rd_cnt[k]), wmem_raddr[k]);
                    rd_cnt[k]++;
                end
            end
        end
    end

    // one phase from update to drained bus
    task automatic run_phase(input ctrl_pkg::phase_e ph, input int cols, input int embd);
        @(negedge clk);
        cur_ph     = ph;
        cur_cols   = cols;
        cur_embd   = embd;
        lim        = (ph == ctrl_pkg::PH_PROJ) ? embd / NUM_CORES : cols;
        total      = NUM_CORES * lim;
        rd_base    = (ph == ctrl_pkg::PH_PROJ) ? ctrl_pkg::PROJ_WEIGHT_BASE : 0;
        rand_ready = (ph == ctrl_pkg::PH_PROJ);  // stall the bus in proj
        acc        = 0;
        done_cnt   = 0;
        for (int c = 0; c < NUM_CORES; c++) begin
            exp_seq[c] = 0;
            rd_cnt[c]  = 0;
            drv_seq[c] = 0;
        end
        @(posedge clk);
        phase_in          <= ph;
        phase_update      <= 1'b1;
        cfg_cols_per_core <= ctrl_pkg::col_cnt_t'(cols);
        cfg_embd_size     <= ctrl_pkg::embd_t'(embd);
        @(posedge clk);
        phase_update <= 1'b0;
        start        <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (done_cnt == 0) @(posedge clk);
        while (acc != total) @(posedge clk);
        @(negedge clk);
        for (int c = 0; c < NUM_CORES; c++) begin
            assert (exp_seq[c] == lim)
                else report_mismatch($sformatf("beats of core %0d", c), lim, exp_seq[c]);
        end
        assert (phase == ph) else report_mismatch("phase", ph, phase);
        assert (recompute_needed == (ph == ctrl_pkg::PH_Q_GEN))
            else report_mismatch("recompute_needed", ph == ctrl_pkg::PH_Q_GEN, recompute_needed);
    endtask

    initial begin
        rst_n             = 1'b0;
        phase_in          = ctrl_pkg::PH_IDLE;
        phase_update      = 1'b0;
        start             = 1'b0;
        cfg_cols_per_core = '0;
        cfg_embd_size     = '0;
        lim               = 0;
        rand_ready        = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (wmem_ren == '0) else report_mismatch("wmem_ren", 0, wmem_ren);
        assert (!gbus_wen) else report_mismatch("gbus_wen", 0, gbus_wen);
        assert (!phase_done) else report_mismatch("phase_done", 0, phase_done);
        assert (!recompute_needed) else report_mismatch("recompute_needed", 0, recompute_needed);
        assert (phase == ctrl_pkg::PH_IDLE)
            else report_mismatch("phase", ctrl_pkg::PH_IDLE, phase);
        run_phase(ctrl_pkg::PH_Q_GEN, 12, 0);
        run_phase(ctrl_pkg::PH_PROJ, 0, 64);
        run_phase(ctrl_pkg::PH_Q_GEN, 12, 0);  // second pass repeats both
        run_phase(ctrl_pkg::PH_PROJ, 0, 64);
        $display("NO ERRORS");
        $finish;
    end

    // watchdog allows 200 cycles per expected write
    initial begin
        #(EXP_WRITES * 200 * CLK_PERIOD);
        stop_on_error("timeout, phase did not complete in time");
    end

endmodule

//--- build.f
ctrl_pkg.sv
wr_if.sv
phase_dispatch.sv
core_ctrl.sv
gbus_write_arb.sv
head_ctrl_top.sv
head_ctrl_sva.sv
tb_head_ctrl_top.sv

//--- Bender.yml
package:
  name: head_ctrl

sources:
  - ctrl_pkg.sv
  - wr_if.sv
  - phase_dispatch.sv
  - core_ctrl.sv
  - gbus_write_arb.sv
  - head_ctrl_top.sv
  - target: test
    files:
      - head_ctrl_sva.sv
      - tb_head_ctrl_top.sv
